// File: sources.f
+incdir+verilog
verilog/ks_out_pkg.sv
verilog/ks_sync_fifo.sv
verilog/ks_col_counter.sv
verilog/ks_mod_switch.sv
verilog/ks_lane_sequencer.sv
verilog/ks_out_process.sv
verification/ks_clk_gen.sv
verification/ks_out_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the key-switch output stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ks_out_tb -f sources.f -o ks_out_sim

./obj_dir/ks_out_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx ">>> PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verification/ks_out_tb.sv
// ----------------------------------------------------------------------
// Testbench for the key-switch output stage
// Key-switch table applied in a loop, LFSR products and bodies,
// reference model for the mod switch, mask and body monitors
// ----------------------------------------------------------------------
`include "ks_out_cfg.svh"

module ks_out_tb
  import ks_out_pkg::*;
();

  localparam int ROWS        = 4;
  localparam int COL_GAP     = 4;
  localparam int WAIT_LIMIT  = 200;
  localparam int IDLE_CYCLES = 16;
  localparam int N_IDX       = `KS_BLOCK_COL_NB * `KS_LBX;
  localparam int N_MASK      = `KS_LWE_K * `KS_PBS_NB;
  localparam int SHIFT       = `KS_OP_W - `KS_LWE_COEF_W;

  logic                   clk;
  logic                   s_rst_n;
  ks_coef_t [`KS_LBX-1:0] prod_i;
  logic     [`KS_LBX-1:0] prod_avail_i;
  logic     [`KS_LBX-1:0] prod_last_pbs_i;
  ks_coef_t               body_i;
  logic                   body_vld_i;
  logic                   body_rdy_o;
  lwe_coef_t              body_o;
  logic                   body_vld_o;
  lwe_coef_t              lwe_o;
  logic                   lwe_vld_o;
  logic                   loop_done_o;
  logic                   lwe_rdy_i;

  // ----------------------------------------------------------------------
  // Stimulus table with one key switch per row
  // ----------------------------------------------------------------------
  string       row_label    [ROWS] = '{"ready_a", "toggle_a", "ready_b", "toggle_b"};
  logic [31:0] row_seed_ofs [ROWS] = '{32'h0, 32'h1f3, 32'h5a5a, 32'hc01};
  logic        row_toggle   [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};

  logic [31:0] lfsr_q;
  logic [31:0] prod_tbl [N_IDX][`KS_PBS_NB];
  logic [31:0] body_tbl [`KS_PBS_NB];
  lwe_coef_t   exp_mask [N_MASK];
  lwe_coef_t   exp_body [`KS_PBS_NB];

  ks_clk_gen u_clk_gen (
    .clk_o     (clk),
    .s_rst_n_o (s_rst_n)
  );

  ks_out_process u_ks_out_process (
    .clk             (clk),
    .s_rst_n         (s_rst_n),
    .prod_i          (prod_i),
    .prod_avail_i    (prod_avail_i),
    .prod_last_pbs_i (prod_last_pbs_i),
    .body_i          (body_i),
    .body_vld_i      (body_vld_i),
    .body_rdy_o      (body_rdy_o),
    .body_o          (body_o),
    .body_vld_o      (body_vld_o),
    .lwe_o           (lwe_o),
    .lwe_vld_o       (lwe_vld_o),
    .loop_done_o     (loop_done_o),
    .lwe_rdy_i       (lwe_rdy_i)
  );

  // ----------------------------------------------------------------------
  // Reference model and random source
  // ----------------------------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w      = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Top bits plus the first dropped bit modulo the coefficient width
  function automatic lwe_coef_t round_to_coef(input logic [31:0] v);
    logic [31:0] q;
    q = (v >> SHIFT) + 32'(v[SHIFT-1]);
    return q[`KS_LWE_COEF_W-1:0];
  endfunction

  task automatic build_row(input int r);
    lfsr_q = 32'h92dd + row_seed_ofs[r];
    for (int x = 0; x < N_IDX; x++) begin
      for (int p = 0; p < `KS_PBS_NB; p++) begin
        draw_word(prod_tbl[x][p]);
      end
    end
    for (int p = 0; p < `KS_PBS_NB; p++) begin
      draw_word(body_tbl[p]);
    end
    // Mask is zero minus product and body is body minus product
    for (int x = 0; x < `KS_LWE_K; x++) begin
      for (int p = 0; p < `KS_PBS_NB; p++) begin
        exp_mask[x * `KS_PBS_NB + p] = round_to_coef(32'h0 - prod_tbl[x][p]);
      end
    end
    for (int p = 0; p < `KS_PBS_NB; p++) begin
      exp_body[p] = round_to_coef(body_tbl[p] - prod_tbl[`KS_LWE_K][p]);
    end
  endtask

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic stop_on_failure();
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic timeout_failure(input string what);
    $display("Timed out while waiting for %s", what);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_quiet(input string tag);
    check_value({tag, " lwe_vld_o"}, 32'h0, 32'(lwe_vld_o));
    check_value({tag, " body_vld_o"}, 32'h0, 32'(body_vld_o));
    check_value({tag, " loop_done_o"}, 32'h0, 32'(loop_done_o));
  endtask

  task automatic check_reset_quiet();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!s_rst_n) begin
      check_quiet("during reset");
      check_value("during reset body_rdy_o", 32'h0, 32'(body_rdy_o));
      waited++;
      if (waited > WAIT_LIMIT) begin
        timeout_failure("reset release");
      end
      @(negedge clk);
    end
    repeat (3) begin
      check_quiet("after reset");
      @(negedge clk);
    end
  endtask

  // ----------------------------------------------------------------------
  // Drivers and monitors
  // ----------------------------------------------------------------------
  task automatic push_body(input logic [31:0] w);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    @(posedge clk);
    body_i.raw <= w;
    body_vld_i <= 1'b1;
    while (!taken) begin
      @(negedge clk);
      if (body_rdy_o) begin
        taken = 1'b1;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          timeout_failure("body_rdy_o");
        end
      end
    end
    // Word moves on this edge
    @(posedge clk);
    body_vld_i <= 1'b0;
  endtask

  task automatic drive_row();
    ks_coef_t [`KS_LBX-1:0] words;
    for (int p = 0; p < `KS_PBS_NB; p++) begin
      push_body(body_tbl[p]);
    end
    for (int c = 0; c < `KS_BLOCK_COL_NB; c++) begin
      for (int p = 0; p < `KS_PBS_NB; p++) begin
        for (int l = 0; l < `KS_LBX; l++) begin
          words[l].raw = prod_tbl[c * `KS_LBX + l][p];
        end
        @(posedge clk);
        prod_i          <= words;
        prod_avail_i    <= '1;
        prod_last_pbs_i <= {`KS_LBX{p == `KS_PBS_NB - 1}};
      end
      // Idle gap lets the sequencer drain both lane FIFOs
      @(posedge clk);
      prod_avail_i    <= '0;
      prod_last_pbs_i <= '0;
      repeat (COL_GAP - 1) @(posedge clk);
    end
  endtask

  task automatic collect_masks(input int r);
    int n;
    int waited;
    int cyc;
    n      = 0;
    waited = 0;
    cyc    = 0;
    while (n < N_MASK) begin
      @(posedge clk);
      lwe_rdy_i <= row_toggle[r] ? cyc[0] : 1'b1;
      cyc++;
      @(negedge clk);
      if (lwe_vld_o && lwe_rdy_i) begin
        check_value($sformatf("%s mask x%0d p%0d", row_label[r], n / `KS_PBS_NB,
                              n % `KS_PBS_NB), 32'(exp_mask[n]), 32'(lwe_o));
        check_value($sformatf("%s loop_done at mask %0d", row_label[r], n),
                    32'(n == N_MASK - 1), 32'(loop_done_o));
        n++;
        waited = 0;
      end else begin
        if (lwe_vld_o) begin
          check_value($sformatf("%s loop_done on stalled mask %0d", row_label[r], n),
                      32'(n == N_MASK - 1), 32'(loop_done_o));
        end else begin
          check_value({row_label[r], " loop_done without valid"},
                      32'h0, 32'(loop_done_o));
        end
        waited++;
        if (waited > WAIT_LIMIT) begin
          timeout_failure($sformatf("mask coefficient %0d of %s", n, row_label[r]));
        end
      end
    end
    @(posedge clk);
    lwe_rdy_i <= 1'b1;
  endtask

  task automatic collect_bodies(input int r);
    int n;
    int waited;
    n      = 0;
    waited = 0;
    while (n < `KS_PBS_NB) begin
      @(negedge clk);
      if (body_vld_o) begin
        check_value($sformatf("%s body p%0d", row_label[r], n),
                    32'(exp_body[n]), 32'(body_o));
        n++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          timeout_failure($sformatf("body coefficient %0d of %s", n, row_label[r]));
        end
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    prod_i          = '0;
    prod_avail_i    = '0;
    prod_last_pbs_i = '0;
    body_i          = '0;
    body_vld_i      = 1'b0;
    lwe_rdy_i       = 1'b1;

    check_reset_quiet();

    for (int r = 0; r < ROWS; r++) begin
      build_row(r);
      fork
        drive_row();
        collect_masks(r);
        collect_bodies(r);
      join
      // Nothing beyond 8 masks and 2 bodies per key switch
      repeat (IDLE_CYCLES) begin
        @(negedge clk);
        check_quiet({row_label[r], " extra output"});
      end
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: verification/ks_clk_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset generator
// Free-running clock, synchronous active-low reset for a few cycles
// ----------------------------------------------------------------------
module ks_clk_gen #(
  parameter int HALF_PERIOD = 2,
  parameter int RST_CYCLES  = 5
) (
  output logic clk_o,
  output logic s_rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset released on the edge after the last reset cycle
  initial begin
    s_rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    s_rst_n_o <= 1'b1;
  end

endmodule

// File: verilog/ks_out_process.sv
// ----------------------------------------------------------------------
// Key-switch output stage, top level
// Body input FIFO, per-lane counters and mod-switch pipes,
// lane FIFOs, lane sequencer and mask output FIFO
// ----------------------------------------------------------------------
`include "ks_out_cfg.svh"

module ks_out_process
  import ks_out_pkg::*;
(
  input  logic                     clk,
  input  logic                     s_rst_n,
  input  ks_coef_t [`KS_LBX-1:0]   prod_i,
  input  logic     [`KS_LBX-1:0]   prod_avail_i,
  input  logic     [`KS_LBX-1:0]   prod_last_pbs_i,
  input  ks_coef_t                 body_i,
  input  logic                     body_vld_i,
  output logic                     body_rdy_o,
  output lwe_coef_t                body_o,
  output logic                     body_vld_o,
  output lwe_coef_t                lwe_o,
  output logic                     lwe_vld_o,
  output logic                     loop_done_o,
  input  logic                     lwe_rdy_i
);

  localparam int LANE_W = `KS_LWE_COEF_W + 2;
  localparam int OUT_W  = `KS_LWE_COEF_W + 1;

  // ----------------------------------------------------------------------
  // Body input FIFO
  // ----------------------------------------------------------------------
  ks_coef_t bfifo_data;
  logic     bfifo_vld;
  logic     bfifo_pop;

  ks_sync_fifo #(
    .WIDTH (`KS_OP_W),
    .DEPTH (`KS_BODY_FIFO_DEPTH)
  ) u_body_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (body_i),
    .in_vld_i   (body_vld_i),
    .in_rdy_o   (body_rdy_o),
    .out_data_o (bfifo_data),
    .out_vld_o  (bfifo_vld),
    .out_rdy_i  (bfifo_pop)
  );

  // ----------------------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------------------
  ks_idx_t   [`KS_LBX-1:0] x_cur;
  logic      [`KS_LBX-1:0] x_body_pop;
  lwe_coef_t [`KS_LBX-1:0] x_mask;
  logic      [`KS_LBX-1:0] x_mask_last_pbs;
  logic      [`KS_LBX-1:0] x_mask_last_mask;
  logic      [`KS_LBX-1:0] x_mask_vld;
  logic      [`KS_LBX-1:0] x_lfifo_in_rdy;
  lwe_coef_t [`KS_LBX-1:0] x_body;
  logic      [`KS_LBX-1:0] x_body_vld;
  lwe_coef_t [`KS_LBX-1:0] l_data;
  logic      [`KS_LBX-1:0] l_last_pbs;
  logic      [`KS_LBX-1:0] l_last_mask;
  logic      [`KS_LBX-1:0] l_vld;
  logic      [`KS_LBX-1:0] l_rdy;

  for (genvar gi = 0; gi < `KS_LBX; gi++) begin : g_lane
    ks_col_counter #(
      .LANE (gi)
    ) u_col_counter (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .avail_i    (prod_avail_i[gi]),
      .last_pbs_i (prod_last_pbs_i[gi]),
      .cur_x_o    (x_cur[gi])
    );

    ks_mod_switch u_mod_switch (
      .clk              (clk),
      .s_rst_n          (s_rst_n),
      .prod_i           (prod_i[gi]),
      .avail_i          (prod_avail_i[gi]),
      .last_pbs_i       (prod_last_pbs_i[gi]),
      .cur_x_i          (x_cur[gi]),
      .body_i           (bfifo_data),
      .body_vld_i       (bfifo_vld),
      .body_pop_o       (x_body_pop[gi]),
      .mask_o           (x_mask[gi]),
      .mask_last_pbs_o  (x_mask_last_pbs[gi]),
      .mask_last_mask_o (x_mask_last_mask[gi]),
      .mask_vld_o       (x_mask_vld[gi]),
      .body_o           (x_body[gi]),
      .body_vld_o       (x_body_vld[gi])
    );

    // Entry is {coef, last_pbs, last_mask}
    ks_sync_fifo #(
      .WIDTH (LANE_W),
      .DEPTH (`KS_LANE_FIFO_DEPTH)
    ) u_lane_fifo (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .in_data_i  ({x_mask[gi], x_mask_last_pbs[gi], x_mask_last_mask[gi]}),
      .in_vld_i   (x_mask_vld[gi]),
      .in_rdy_o   (x_lfifo_in_rdy[gi]),
      .out_data_o ({l_data[gi], l_last_pbs[gi], l_last_mask[gi]}),
      .out_vld_o  (l_vld[gi]),
      .out_rdy_i  (l_rdy[gi])
    );

    // Mask pipe has no back-pressure, the lane FIFO must have room
    a_lane_fifo_room : assert property (
      @(posedge clk) disable iff (!s_rst_n)
      x_mask_vld[gi] |-> x_lfifo_in_rdy[gi]
    );
  end

  // Only lane 0 ever carries the body
  assign bfifo_pop = |x_body_pop;

  always_comb begin
    body_o     = '0;
    body_vld_o = 1'b0;
    for (int i = 0; i < `KS_LBX; i++) begin
      body_o     = body_o | x_body[i];
      body_vld_o = body_vld_o | x_body_vld[i];
    end
  end

  // ----------------------------------------------------------------------
  // Reorder and output FIFO
  // ----------------------------------------------------------------------
  lwe_coef_t seq_data;
  logic      seq_loop_done;
  logic      seq_vld;
  logic      seq_rdy;
  logic      ofifo_loop_done;

  ks_lane_sequencer u_lane_sequencer (
    .clk              (clk),
    .s_rst_n          (s_rst_n),
    .lane_data_i      (l_data),
    .lane_last_pbs_i  (l_last_pbs),
    .lane_last_mask_i (l_last_mask),
    .lane_vld_i       (l_vld),
    .lane_rdy_o       (l_rdy),
    .out_data_o       (seq_data),
    .out_loop_done_o  (seq_loop_done),
    .out_vld_o        (seq_vld),
    .out_rdy_i        (seq_rdy)
  );

  ks_sync_fifo #(
    .WIDTH (OUT_W),
    .DEPTH (`KS_OUT_FIFO_DEPTH)
  ) u_out_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  ({seq_loop_done, seq_data}),
    .in_vld_i   (seq_vld),
    .in_rdy_o   (seq_rdy),
    .out_data_o ({ofifo_loop_done, lwe_o}),
    .out_vld_o  (lwe_vld_o),
    .out_rdy_i  (lwe_rdy_i)
  );

  // Flag only counts with a valid head entry
  assign loop_done_o = ofifo_loop_done & lwe_vld_o;

endmodule

// File: verilog/ks_lane_sequencer.sv
// ----------------------------------------------------------------------
// Lane sequencer
// Drains the lane FIFOs in coefficient order, all PBS of one
// index before the next, and flags the end of the key switch
// ----------------------------------------------------------------------
`include "ks_out_cfg.svh"

module ks_lane_sequencer
  import ks_out_pkg::*;
(
  input  logic                        clk,
  input  logic                        s_rst_n,
  input  lwe_coef_t [`KS_LBX-1:0]     lane_data_i,
  input  logic      [`KS_LBX-1:0]     lane_last_pbs_i,
  input  logic      [`KS_LBX-1:0]     lane_last_mask_i,
  input  logic      [`KS_LBX-1:0]     lane_vld_i,
  output logic      [`KS_LBX-1:0]     lane_rdy_o,
  output lwe_coef_t                   out_data_o,
  output logic                        out_loop_done_o,
  output logic                        out_vld_o,
  input  logic                        out_rdy_i
);

  localparam ks_lane_t LAST_LANE = ks_lane_t'(`KS_LBX - 1);

  ks_lane_t sel_q;
  logic     moved;
  logic     cur_last_pbs;
  logic     cur_last_mask;

  assign out_data_o      = lane_data_i[sel_q];
  assign out_vld_o       = lane_vld_i[sel_q];
  assign cur_last_pbs    = lane_last_pbs_i[sel_q];
  assign cur_last_mask   = lane_last_mask_i[sel_q];
  assign out_loop_done_o = cur_last_pbs & cur_last_mask;
  assign moved           = out_vld_o & out_rdy_i;

  // Only the selected lane sees ready
  always_comb begin
    for (int i = 0; i < `KS_LBX; i++) begin
      lane_rdy_o[i] = (sel_q == ks_lane_t'(i)) & out_rdy_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sel_q <= '0;
    end else if (moved && cur_last_pbs) begin
      // Last mask index may end on any lane
      if (sel_q == LAST_LANE || cur_last_mask) begin
        sel_q <= '0;
      end else begin
        sel_q <= sel_q + 1'b1;
      end
    end
  end

endmodule

// File: verilog/ks_mod_switch.sv
// ----------------------------------------------------------------------
// Per-lane subtract and mod-switch pipeline
// s0 subtracts the product from the body or from zero
// s1 rounds to the LWE coefficient width
// s2 steers the result to the mask or the body output
// ----------------------------------------------------------------------
`include "ks_out_cfg.svh"

module ks_mod_switch
  import ks_out_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,
  input  ks_coef_t  prod_i,
  input  logic      avail_i,
  input  logic      last_pbs_i,
  input  ks_idx_t   cur_x_i,
  input  ks_coef_t  body_i,
  input  logic      body_vld_i,
  output logic      body_pop_o,
  output lwe_coef_t mask_o,
  output logic      mask_last_pbs_o,
  output logic      mask_last_mask_o,
  output logic      mask_vld_o,
  output lwe_coef_t body_o,
  output logic      body_vld_o
);

  logic                is_body;
  logic                is_last_mask;
  logic                keep;
  logic [`KS_OP_W-1:0] base;

  // Pipeline stage registers
  logic      s0_vld;
  logic      s1_vld;
  logic      s2_mask_vld;
  logic      s2_body_vld;
  ks_coef_t  s0_coef;
  logic      s0_is_body;
  logic      s0_last_mask;
  logic      s0_last_pbs;
  lwe_coef_t s1_mdsw;
  logic      s1_is_body;
  logic      s1_last_mask;
  logic      s1_last_pbs;
  lwe_coef_t s2_mask;
  lwe_coef_t s2_body;
  logic      s2_last_mask;
  logic      s2_last_pbs;

  assign is_body      = (cur_x_i == ks_idx_t'(`KS_LWE_K));
  assign is_last_mask = (cur_x_i == ks_idx_t'(`KS_LWE_K - 1));
  // Indices past the body are surplus columns
  assign keep         = (cur_x_i <= ks_idx_t'(`KS_LWE_K));
  assign base         = is_body ? body_i.raw : '0;
  assign body_pop_o   = avail_i & is_body;

  // ----------------------------------------------------------------------
  // Control pipe
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_vld      <= 1'b0;
      s1_vld      <= 1'b0;
      s2_mask_vld <= 1'b0;
      s2_body_vld <= 1'b0;
    end else begin
      s0_vld      <= avail_i & keep;
      s1_vld      <= s0_vld;
      s2_mask_vld <= s1_vld & ~s1_is_body;
      s2_body_vld <= s1_vld & s1_is_body;
    end
  end

  // ----------------------------------------------------------------------
  // Data pipe
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    // Modulo 2^OP_W, no reduction needed
    s0_coef.raw  <= base - prod_i.raw;
    s0_is_body   <= is_body;
    s0_last_mask <= is_last_mask;
    s0_last_pbs  <= last_pbs_i;
    // Round to nearest on the bit below hi
    s1_mdsw      <= s0_coef.split.hi + lwe_coef_t'(s0_coef.split.rnd);
    s1_is_body   <= s0_is_body;
    s1_last_mask <= s0_last_mask;
    s1_last_pbs  <= s0_last_pbs;
    s2_mask      <= s1_mdsw;
    s2_body      <= s1_is_body ? s1_mdsw : '0;
    s2_last_mask <= s1_last_mask;
    s2_last_pbs  <= s1_last_pbs;
  end

  assign mask_o           = s2_mask;
  assign mask_last_pbs_o  = s2_last_pbs;
  assign mask_last_mask_o = s2_last_mask;
  assign mask_vld_o       = s2_mask_vld;
  assign body_o           = s2_body;
  assign body_vld_o       = s2_body_vld;

  // Body word must already sit in the body FIFO
  a_body_present : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    body_pop_o |-> body_vld_i
  );

endmodule

// File: verilog/ks_col_counter.sv
// ----------------------------------------------------------------------
// Per-lane column counter
// Tracks the column and the LWE coefficient index of one lane
// ----------------------------------------------------------------------
`include "ks_out_cfg.svh"

module ks_col_counter
  import ks_out_pkg::*;
#(
  parameter int LANE = 0
) (
  input  logic    clk,
  input  logic    s_rst_n,
  input  logic    avail_i,
  input  logic    last_pbs_i,
  output ks_idx_t cur_x_o
);

  localparam logic [`KS_COL_CNT_W-1:0] LAST_COL = `KS_BLOCK_COL_NB - 1;
  localparam ks_idx_t FIRST_X = ks_idx_t'(LANE);
  localparam ks_idx_t X_STEP  = ks_idx_t'(`KS_LBX);

  logic [`KS_COL_CNT_W-1:0] col_q;
  ks_idx_t                  x_q;
  logic                     col_done;

  // A column ends with its last PBS
  assign col_done = avail_i & last_pbs_i;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      col_q <= '0;
      x_q   <= FIRST_X;
    end else if (col_done) begin
      if (col_q == LAST_COL) begin
        // Wrap for the next key switch
        col_q <= '0;
        x_q   <= FIRST_X;
      end else begin
        col_q <= col_q + 1'b1;
        x_q   <= x_q + X_STEP;
      end
    end
  end

  assign cur_x_o = x_q;

  // A last PBS flag only comes with a product
  a_last_pbs_with_avail : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    last_pbs_i |-> avail_i
  );

endmodule

// File: verilog/ks_sync_fifo.sv
// ----------------------------------------------------------------------
// Register FIFO with valid/ready on both sides
// Write shows at the head one cycle later
// ----------------------------------------------------------------------
module ks_sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,
  input  logic [WIDTH-1:0] in_data_i,
  input  logic             in_vld_i,
  output logic             in_rdy_o,
  output logic [WIDTH-1:0] out_data_o,
  output logic             out_vld_o,
  input  logic             out_rdy_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;
  logic             rdy_q;
  logic             push;
  logic             pop;

  assign push      = in_vld_i & rdy_q;
  assign pop       = out_vld_o & out_rdy_i;
  assign count_nxt = count + CNT_W'(push) - CNT_W'(pop);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rdy_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_nxt;
      rdy_q <= (count_nxt != FULL_CNT);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  assign in_rdy_o   = rdy_q;
  assign out_vld_o  = (count != '0);
  assign out_data_o = mem[rd_ptr];

  // Producer holds valid until the word is taken
  a_in_vld_held : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    (in_vld_i && !in_rdy_o) |=> in_vld_i
  );

endmodule

// File: verilog/ks_out_pkg.sv
// ----------------------------------------------------------------------
// Shared types of the key-switch output stage
// Coefficient word with raw and mod-switch views, index, LWE
// coefficient and lane number types
// ----------------------------------------------------------------------
`include "ks_out_cfg.svh"

package ks_out_pkg;

  // Mod-switch view of an operand word
  typedef struct packed {
    logic [`KS_LWE_COEF_W-1:0]          hi;
    logic                               rnd;
    logic [`KS_OP_W-`KS_LWE_COEF_W-2:0] lo;
  } ks_split_t;

  // Same word, subtracted as raw and rounded through split
  typedef union packed {
    logic [`KS_OP_W-1:0] raw;
    ks_split_t           split;
  } ks_coef_t;

  // Coefficient index 0..7
  typedef logic [`KS_IDX_W-1:0] ks_idx_t;

  typedef logic [`KS_LWE_COEF_W-1:0] lwe_coef_t;

  typedef logic [`KS_LANE_W-1:0] ks_lane_t;

endpackage

// File: verilog/ks_out_cfg.svh
// ----------------------------------------------------------------------
// Size definitions for the key-switch output stage
// Lane count, operand and coefficient widths, LWE geometry
// and FIFO depths
// ----------------------------------------------------------------------
`ifndef KS_OUT_CFG_SVH
`define KS_OUT_CFG_SVH

// Column lanes and operand widths
`define KS_LBX             2
`define KS_OP_W            32
`define KS_LWE_COEF_W      12

// LWE geometry, the body sits at index KS_LWE_K
`define KS_LWE_K           4
`define KS_PBS_NB          2
`define KS_BLOCK_COL_NB    3

// Derived index, lane and column counter widths
`define KS_IDX_W           3
`define KS_LANE_W          1
`define KS_COL_CNT_W       2

// FIFO depths
`define KS_LANE_FIFO_DEPTH 2
`define KS_OUT_FIFO_DEPTH  8
`define KS_BODY_FIFO_DEPTH 2

`endif
